// File: source/tft_macros.svh
`ifndef TFT_MACROS_SVH
`define TFT_MACROS_SVH

// Horizontal phase lengths, in clkTFT cycles
`define H_SYNC 4
`define H_BACK 4
`define H_DISPLAY 16
`define H_FRONT 4

// Vertical phase lengths, in lines
`define V_SYNC 2
`define V_BACK 2
`define V_DISPLAY 6
`define V_FRONT 2

// Counter widths, sized for the longest phase
`define H_CNT_W 5
`define V_CNT_W 3

// Pixel FIFO
`define FIFO_DEPTH 32
`define LEVEL_W 6

`endif

// File: source/tft_pkg.sv
`default_nettype none

`include "tft_macros.svh"

package tft_pkg;

	// 5-6-5 word as written by the host
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} pixel_565_t;

	// Panel colour, 8 bits per channel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_888_t;

	typedef logic [`H_CNT_W-1:0] hcount_t;
	typedef logic [`V_CNT_W-1:0] vcount_t;
	typedef logic [`LEVEL_W-1:0] fifo_level_t;

	// Shared by the horizontal and vertical counters
	typedef enum logic [1:0] {
		SYNC,
		BACK,
		DISPLAY,
		FRONT
	} phase_t;

	// Undelayed video timing, syncs active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
		logic display;
	} tft_timing_t;

	// Phases run in a fixed ring
	function automatic phase_t next_phase(input phase_t phase);
		return phase_t'(phase + 2'd1);
	endfunction

endpackage

`default_nettype wire

// File: source/tft_fifo.sv
`default_nettype none

`include "tft_macros.svh"

module tft_fifo (
	input wire clkTFT,
	input wire n_reset,
	input wire tft_pkg::pixel_565_t wr_data,
	input wire wr_en,
	input wire rd_en,
	input wire flush,
	output tft_pkg::pixel_565_t rd_data,
	output logic rd_valid,
	output tft_pkg::fifo_level_t level,
	output logic empty,
	output logic full
);

	localparam int ADDR_W = $clog2(`FIFO_DEPTH);

	tft_pkg::pixel_565_t mem [`FIFO_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic do_write;
	logic do_read;

	// Wrap at the last entry, so the depth need not be a power of two
	function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
		if (ptr == ADDR_W'(`FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = level == tft_pkg::fifo_level_t'(`FIFO_DEPTH);
	assign empty = level == '0;

	// Flush wins over a pending write
	assign do_write = wr_en && !full && !flush;
	assign do_read = rd_en && !empty;

	always_ff @(posedge clkTFT) begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	// Registered read port, word valid one cycle after the strobe
	always_ff @(posedge clkTFT) begin
		if (do_read)
			rd_data <= mem[rd_ptr];
	end

	always_ff @(posedge clkTFT or negedge n_reset) begin
		if (!n_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			rd_valid <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= do_read;
			if (do_write)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_read)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_write, do_read})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/tft_timing.sv
`default_nettype none

`include "tft_macros.svh"

module tft_timing (
	input wire clkTFT,
	input wire n_reset,
	output tft_pkg::tft_timing_t timing
);

	tft_pkg::phase_t h_phase;
	tft_pkg::phase_t v_phase;
	tft_pkg::hcount_t h_count;
	tft_pkg::vcount_t v_count;
	logic h_last;
	logic line_end;

	// Reload values are length minus one, the counters run down to zero
	function automatic tft_pkg::hcount_t h_length(input tft_pkg::phase_t phase);
		case (phase)
			tft_pkg::SYNC: return tft_pkg::hcount_t'(`H_SYNC - 1);
			tft_pkg::BACK: return tft_pkg::hcount_t'(`H_BACK - 1);
			tft_pkg::DISPLAY: return tft_pkg::hcount_t'(`H_DISPLAY - 1);
			default: return tft_pkg::hcount_t'(`H_FRONT - 1);
		endcase
	endfunction

	function automatic tft_pkg::vcount_t v_length(input tft_pkg::phase_t phase);
		case (phase)
			tft_pkg::SYNC: return tft_pkg::vcount_t'(`V_SYNC - 1);
			tft_pkg::BACK: return tft_pkg::vcount_t'(`V_BACK - 1);
			tft_pkg::DISPLAY: return tft_pkg::vcount_t'(`V_DISPLAY - 1);
			default: return tft_pkg::vcount_t'(`V_FRONT - 1);
		endcase
	endfunction

	assign h_last = h_count == '0;

	// Last clock of the front porch, next clock opens a new line
	assign line_end = h_last && h_phase == tft_pkg::FRONT;

	// Horizontal phase FSM
	always_ff @(posedge clkTFT or negedge n_reset) begin
		if (!n_reset) begin
			h_phase <= tft_pkg::SYNC;
			h_count <= h_length(tft_pkg::SYNC);
		end else if (h_last) begin
			h_phase <= tft_pkg::next_phase(h_phase);
			h_count <= h_length(tft_pkg::next_phase(h_phase));
		end else begin
			h_count <= h_count - 1'b1;
		end
	end

	// Vertical phase FSM, stepped once per line
	always_ff @(posedge clkTFT or negedge n_reset) begin
		if (!n_reset) begin
			v_phase <= tft_pkg::SYNC;
			v_count <= v_length(tft_pkg::SYNC);
		end else if (line_end) begin
			if (v_count == '0) begin
				v_phase <= tft_pkg::next_phase(v_phase);
				v_count <= v_length(tft_pkg::next_phase(v_phase));
			end else begin
				v_count <= v_count - 1'b1;
			end
		end
	end

	// Timing outputs, one register after the phases
	always_ff @(posedge clkTFT or negedge n_reset) begin
		if (!n_reset) begin
			timing.hsync_n <= 1'b1;
			timing.vsync_n <= 1'b1;
			timing.hblank <= 1'b1;
			timing.vblank <= 1'b1;
			timing.display <= 1'b0;
		end else begin
			timing.hsync_n <= h_phase != tft_pkg::SYNC;
			timing.vsync_n <= v_phase != tft_pkg::SYNC;
			timing.hblank <= h_phase != tft_pkg::DISPLAY;
			timing.vblank <= v_phase != tft_pkg::DISPLAY;
			// Active area needs both counters in display
			timing.display <= h_phase == tft_pkg::DISPLAY &&
				v_phase == tft_pkg::DISPLAY;
		end
	end

endmodule

`default_nettype wire

// File: source/tft_pixel_out.sv
`default_nettype none

module tft_pixel_out (
	input wire clkTFT,
	input wire n_reset,
	input wire tft_pkg::tft_timing_t timing_in,
	input wire tft_pkg::pixel_565_t pixel,
	input wire pixel_valid,
	output logic hsync,
	output logic vsync,
	output logic de,
	output tft_pkg::pixel_888_t rgb
);

	// Low bits of each channel are left at zero
	function automatic tft_pkg::pixel_888_t widen(input tft_pkg::pixel_565_t p);
		tft_pkg::pixel_888_t w;
		w.r = {p.r, 3'b000};
		w.g = {p.g, 2'b00};
		w.b = {p.b, 3'b000};
		return w;
	endfunction

	// Panel timing, one clock behind the status outputs
	always_ff @(posedge clkTFT or negedge n_reset) begin
		if (!n_reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
		end else begin
			hsync <= timing_in.hsync_n;
			vsync <= timing_in.vsync_n;
			de <= timing_in.display;
		end
	end

	// The FIFO word lands on the same edge as de
	// Black on blanking and on underflow
	assign rgb = (de && pixel_valid) ? widen(pixel) : '0;

endmodule

`default_nettype wire

// File: source/tft.sv
`default_nettype none

module tft (
	input wire clkTFT,
	input wire n_reset,
	input wire tft_pkg::pixel_565_t pixel_in,
	input wire pixel_wr,
	output tft_pkg::fifo_level_t fifo_level,
	output logic fifo_empty,
	output logic fifo_full,
	output logic tft_hblank,
	output logic tft_vblank,
	output logic disp,
	output logic dclk,
	output logic de,
	output logic hsync,
	output logic vsync,
	output tft_pkg::pixel_888_t rgb
);

	tft_pkg::tft_timing_t timing;
	tft_pkg::pixel_565_t rd_data;
	logic rd_valid;

	// Panel stays enabled while out of reset
	assign disp = n_reset;
	assign dclk = clkTFT;

	assign tft_hblank = timing.hblank;
	assign tft_vblank = timing.vblank;

	// Vertical blanking empties the FIFO, every frame starts clean
	tft_fifo u_fifo (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.wr_data(pixel_in),
		.wr_en(pixel_wr),
		.rd_en(timing.display),
		.flush(timing.vblank),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.level(fifo_level),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	tft_timing u_timing (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.timing(timing)
	);

	tft_pixel_out u_pixel_out (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.timing_in(timing),
		.pixel(rd_data),
		.pixel_valid(rd_valid),
		.hsync(hsync),
		.vsync(vsync),
		.de(de),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// File: bench/tft_properties.sv
`default_nettype none

`include "tft_macros.svh"

module tft_properties (
	input wire clkTFT,
	input wire n_reset,
	input wire de,
	input wire hsync,
	input wire vsync,
	input wire fifo_full,
	input wire fifo_empty,
	input wire tft_pkg::fifo_level_t fifo_level
);

	int sync_fails = 0;
	int flag_fails = 0;
	int level_fails = 0;

	// Active pixels only outside both sync pulses
	de_outside_sync: assert property (@(posedge clkTFT) disable iff (!n_reset)
		de |-> hsync && vsync)
		else begin
			$error("de high during a sync pulse");
			sync_fails = sync_fails + 1;
		end

	flags_exclusive: assert property (@(posedge clkTFT) disable iff (!n_reset)
		!(fifo_full && fifo_empty))
		else begin
			$error("FIFO full and empty at the same time");
			flag_fails = flag_fails + 1;
		end

	level_in_range: assert property (@(posedge clkTFT) disable iff (!n_reset)
		fifo_level <= tft_pkg::fifo_level_t'(`FIFO_DEPTH))
		else begin
			$error("FIFO level above the depth");
			level_fails = level_fails + 1;
		end

endmodule

`default_nettype wire

// File: bench/tft_checker.sv
`default_nettype none

`include "tft_macros.svh"

module tft_checker (
	input wire clkTFT,
	input wire n_reset,
	input wire tft_pkg::pixel_565_t pixel_in,
	input wire pixel_wr,
	input wire tft_pkg::fifo_level_t fifo_level,
	input wire fifo_empty,
	input wire fifo_full,
	input wire tft_hblank,
	input wire tft_vblank,
	input wire disp,
	input wire dclk,
	input wire de,
	input wire hsync,
	input wire vsync,
	input wire tft_pkg::pixel_888_t rgb,
	output int mismatches
);

	localparam int LINE = `H_SYNC + `H_BACK + `H_DISPLAY + `H_FRONT;
	localparam int ROWS = `V_SYNC + `V_BACK + `V_DISPLAY + `V_FRONT;

	typedef struct packed {
		int stamp;
		tft_pkg::pixel_565_t word;
	} entry_t;

	// Accepted words not yet shown, oldest first
	entry_t accepted [$];
	int edge_count = 0;
	int error_count = 0;
	logic reset_seen = 1'b0;

	assign mismatches = error_count;

	// Timing at a clock position counted from the start of frame 0
	function automatic tft_pkg::tft_timing_t expected_timing(input int pos);
		tft_pkg::tft_timing_t t;
		int hx;
		int row;
		logic h_act;
		logic v_act;
		hx = pos % LINE;
		row = (pos / LINE) % ROWS;
		h_act = hx >= `H_SYNC + `H_BACK && hx < LINE - `H_FRONT;
		v_act = row >= `V_SYNC + `V_BACK && row < ROWS - `V_FRONT;
		// Negative position means the reset values
		t.hsync_n = pos < 0 || hx >= `H_SYNC;
		t.vsync_n = pos < 0 || row >= `V_SYNC;
		t.hblank = pos < 0 || !h_act;
		t.vblank = pos < 0 || !v_act;
		t.display = pos >= 0 && h_act && v_act;
		return t;
	endfunction

	// Each channel left aligned with zero fill
	function automatic tft_pkg::pixel_888_t widen_565(input tft_pkg::pixel_565_t p);
		return {p.r, 3'b000, p.g, 2'b00, p.b, 3'b000};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	// dclk must follow clkTFT in both levels
	always @(clkTFT) begin
		#1;
		check_value("dclk", 32'(clkTFT), 32'(dclk));
	end

	always @(posedge clkTFT) begin
		tft_pkg::tft_timing_t st;
		tft_pkg::tft_timing_t pin;
		tft_pkg::pixel_888_t exp_rgb;
		if (!n_reset) begin
			// First reset edge only loads the flops
			if (reset_seen)
				check_value("reset state", 32'h0f,
					32'({disp, de, |rgb, hsync, vsync, tft_hblank, tft_vblank}));
			reset_seen = 1'b1;
			edge_count = 0;
			accepted.delete();
		end else begin
			edge_count = edge_count + 1;
			// Status lags the phase counters by one clock, the pins by two
			st = expected_timing(edge_count - 2);
			pin = expected_timing(edge_count - 3);
			check_value("blank status", 32'({st.hblank, st.vblank}),
				32'({tft_hblank, tft_vblank}));
			check_value("panel timing", 32'({pin.hsync_n, pin.vsync_n, pin.display}),
				32'({hsync, vsync, de}));
			check_value("disp", 32'd1, 32'(disp));
			exp_rgb = '0;
			if (pin.display && accepted.size() > 0 && accepted[0].stamp <= edge_count - 2) begin
				exp_rgb = widen_565(accepted[0].word);
				void'(accepted.pop_front());
			end
			check_value("rgb", {8'd0, exp_rgb}, {8'd0, rgb});
			check_value("fifo level", accepted.size(), 32'(fifo_level));
			check_value("fifo flags", 32'({accepted.size() == 0, accepted.size() == `FIFO_DEPTH}),
				32'({fifo_empty, fifo_full}));
			// Flushed on every vblank cycle, writes refused meanwhile
			if (st.vblank)
				accepted.delete();
			else if (pixel_wr && accepted.size() < `FIFO_DEPTH)
				accepted.push_back('{stamp: edge_count, word: pixel_in});
		end
	end

endmodule

`default_nettype wire

// File: bench/tft_tb.sv
`default_nettype none

`include "tft_macros.svh"

module tft_tb;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CYCLES = (`H_SYNC + `H_BACK + `H_DISPLAY + `H_FRONT) *
		(`V_SYNC + `V_BACK + `V_DISPLAY + `V_FRONT);
	localparam int RUN_CYCLES = 4 * FRAME_CYCLES;
	// Reset plus four frames, with slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 640;
	localparam int FULL_FRAME = 2;

	logic clkTFT = 1'b0;
	logic n_reset;
	tft_pkg::pixel_565_t pixel_in;
	logic pixel_wr;
	tft_pkg::fifo_level_t fifo_level;
	logic fifo_empty;
	logic fifo_full;
	logic tft_hblank;
	logic tft_vblank;
	logic disp;
	logic dclk;
	logic de;
	logic hsync;
	logic vsync;
	tft_pkg::pixel_888_t rgb;
	int mismatches;
	int cycle_count = 0;
	logic full_seen = 1'b0;
	logic [31:0] lcg_state;

	always #(PERIOD / 2) clkTFT = ~clkTFT;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	tft dut (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.pixel_in(pixel_in),
		.pixel_wr(pixel_wr),
		.fifo_level(fifo_level),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.tft_hblank(tft_hblank),
		.tft_vblank(tft_vblank),
		.disp(disp),
		.dclk(dclk),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb)
	);

	tft_checker u_checker (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.pixel_in(pixel_in),
		.pixel_wr(pixel_wr),
		.fifo_level(fifo_level),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.tft_hblank(tft_hblank),
		.tft_vblank(tft_vblank),
		.disp(disp),
		.dclk(dclk),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb),
		.mismatches(mismatches)
	);

	bind tft tft_properties u_properties (
		.clkTFT(clkTFT),
		.n_reset(n_reset),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.fifo_full(fifo_full),
		.fifo_empty(fifo_empty),
		.fifo_level(fifo_level)
	);

	always @(posedge clkTFT) begin
		cycle_count = cycle_count + 1;
		if (fifo_full)
			full_seen = 1'b1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int assert_fails;
		int other_errors;
		n_reset = 1'b0;
		pixel_in = '0;
		pixel_wr = 1'b0;
		lcg_state = 32'hc139_a6a3;
		other_errors = 0;
		repeat (RESET_CYCLES) @(negedge clkTFT);
		n_reset = 1'b1;
		for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
			lcg_state = lcg_next(lcg_state);
			pixel_in = lcg_state[31:16];
			// Fill frame writes every cycle, early frames spare vblank
			if (cycle / FRAME_CYCLES == FULL_FRAME)
				pixel_wr = 1'b1;
			else if (cycle / FRAME_CYCLES < FULL_FRAME)
				pixel_wr = lcg_state[15] && !tft_vblank;
			else
				pixel_wr = lcg_state[15];
			@(negedge clkTFT);
		end
		pixel_wr = 1'b0;
		@(negedge clkTFT);
		if (!full_seen) begin
			$display("Error: the FIFO never became full during the fill frame");
			other_errors = other_errors + 1;
		end
		assert_fails = dut.u_properties.sync_fails + dut.u_properties.flag_fails +
			dut.u_properties.level_fails;
		$display("Errors: %0d mismatches, %0d assertion failures, %0d other",
			mismatches, assert_fails, other_errors);
		if (mismatches + assert_fails + other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/tft_pkg.sv
source/tft_fifo.sv
source/tft_timing.sv
source/tft_pixel_out.sv
source/tft.sv
bench/tft_properties.sv
bench/tft_checker.sv
bench/tft_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build tft_tb with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module tft_tb -o tft_sim
	./obj_dir/tft_sim +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
